/* project.f */
source/axi_mem_pkg.sv
source/mem_lane_if.sv
source/beat_tag_if.sv
source/burst_engine.sv
source/byte_lane_bank.sv
source/read_response.sv
source/axi_mem_top.sv
verification/tb_axi_mem.sv

/* Bender.yml */
package:
  name: axi_mem

sources:
  - source/axi_mem_pkg.sv
  - source/mem_lane_if.sv
  - source/beat_tag_if.sv
  - source/burst_engine.sv
  - source/byte_lane_bank.sv
  - source/read_response.sv
  - source/axi_mem_top.sv
  - target: test
    files:
      - verification/tb_axi_mem.sv

/* verification/tb_axi_mem.sv */
// Directed testbench for the AXI4 slave memory
// Byte-array model predicts every B and R response, one task per burst behavior
`timescale 1ns/1ps

module tb_axi_mem;

    localparam int TIMEOUT = 200;  // Cycles allowed for each wait

    logic clk = 1'b0;
    logic reset;
    logic arvalid, arready, rvalid, rready, rlast, awvalid, awready;
    logic wvalid, wready, wlast, bvalid, bready;
    axi_mem_pkg::id_t    arid, rid, awid, bid;
    axi_mem_pkg::addr_t  araddr, awaddr;
    axi_mem_pkg::len_t   arlen, awlen;
    axi_mem_pkg::size_t  arsize, awsize;
    axi_mem_pkg::burst_t arburst, awburst;
    axi_mem_pkg::data_t  rdata, wdata;
    axi_mem_pkg::strb_t  wstrb;
    axi_mem_pkg::resp_t  rresp, bresp;

    axi_mem_pkg::byte_t model [axi_mem_pkg::MEM_BYTES];  // Expected memory contents
    axi_mem_pkg::data_t beat_data [16];                  // W payload of the next burst
    axi_mem_pkg::strb_t beat_strb [16];
    int     errors   = 0;
    int     timeouts = 0;
    integer seed     = 32'h17b2fdda;

    always #5 clk = ~clk;

    axi_mem_top dut (.*);

    // Address of the beat after addr, by the AXI burst rules
    function automatic int step_addr(input int addr, input int size,
                                     input axi_mem_pkg::burst_t burst, input int len);
        int nbytes;
        int cont;
        int base;
        int next;
        nbytes = 1 << size;
        cont   = nbytes * (len + 1);             // WRAP container
        base   = addr - (addr % cont);
        next   = addr - (addr % nbytes) + nbytes;
        if (burst == axi_mem_pkg::FIXED)
            next = addr;
        else if (burst == axi_mem_pkg::WRAP && next >= base + cont)
            next = base;
        return next;
    endfunction

    // Beat runs past the end of memory
    function automatic bit beat_bad(input int addr, input int size);
        return (addr + (1 << size)) > axi_mem_pkg::MEM_BYTES;
    endfunction

    function automatic axi_mem_pkg::data_t model_word(input int addr);
        int base;
        base = addr & ~3;   // Lane 0 byte of the word
        return {model[base+3], model[base+2], model[base+1], model[base]};
    endfunction

    function automatic logic signal_high(input string name);
        case (name)
            "arready": return arready;
            "awready": return awready;
            "wready":  return wready;
            default:   return bvalid;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    // Drive point, 1 ns after the rising edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
    endtask

    // Samples at falling edges, handshake then lands on the next rising edge
    task automatic wait_until_high(input string name);
        int t;
        t = 0;
        @(negedge clk);
        while (!signal_high(name) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!signal_high(name)) begin
            $display("Timeout: %s never went high", name);
            timeouts++;
        end
    endtask

    task automatic fill_beats(input int n, input axi_mem_pkg::strb_t strb);
        for (int i = 0; i < n; i++) begin
            beat_data[i] = $random(seed);
            beat_strb[i] = strb;
        end
    endtask

    task automatic write_burst(input axi_mem_pkg::id_t id, input int addr, input int len,
                               input int size, input axi_mem_pkg::burst_t burst);
        int a;
        bit bad;
        a       = addr;
        bad     = 1'b0;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awsize  = size;
        awburst = burst;
        awvalid = 1'b1;
        wait_until_high("awready");
        advance_cycle();
        awvalid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            wvalid = 1'b1;
            wdata  = beat_data[i];
            wstrb  = beat_strb[i];
            wlast  = (i == len);
            wait_until_high("wready");
            advance_cycle();
            if (beat_bad(a, size))
                bad = 1'b1;                      // Nothing written for this beat
            else
                for (int l = 0; l < 4; l++)
                    if (beat_strb[i][l])
                        model[(a & ~3) + l] = beat_data[i][l*8 +: 8];
            a = step_addr(a, size, burst, len);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        bready = 1'b1;
        wait_until_high("bvalid");
        compare_value("bid", id, bid);
        compare_value("bresp", bad ? axi_mem_pkg::RESP_DECERR : axi_mem_pkg::RESP_OKAY, bresp);
        advance_cycle();
        bready = 1'b0;
    endtask

    task automatic read_burst(input axi_mem_pkg::id_t id, input int addr, input int len,
                              input int size, input axi_mem_pkg::burst_t burst,
                              input bit random_ready);
        int          a;
        int          beat;
        int          t;
        logic [39:0] held;        // Payload seen while stalled
        logic        hold_check;
        a          = addr;
        beat       = 0;
        t          = 0;
        hold_check = 1'b0;
        arid       = id;
        araddr     = addr;
        arlen      = len;
        arsize     = size;
        arburst    = burst;
        arvalid    = 1'b1;
        rready     = 1'b1;
        wait_until_high("arready");
        advance_cycle();
        arvalid = 1'b0;
        while (beat <= len && t < TIMEOUT) begin
            @(negedge clk);
            if (hold_check && {rvalid, rid, rdata, rresp, rlast} !== held) begin
                $display("[ERROR] R payload: expected %h, got %h", held,
                         {rvalid, rid, rdata, rresp, rlast});
                errors++;
            end
            hold_check = rvalid && !rready;
            held       = {rvalid, rid, rdata, rresp, rlast};
            if (rvalid && rready) begin
                compare_value("rdata", beat_bad(a, size) ? '0 : model_word(a), rdata);
                compare_value("rid", id, rid);
                compare_value("rresp", beat_bad(a, size) ? axi_mem_pkg::RESP_DECERR
                                                         : axi_mem_pkg::RESP_OKAY, rresp);
                compare_value("rlast", beat == len, rlast);
                a = step_addr(a, size, burst, len);
                beat++;
            end
            advance_cycle();
            rready = random_ready ? (($random(seed) & 1) != 0) : 1'b1;
            t++;
        end
        if (beat <= len) begin
            $display("Timeout: read burst gave %0d of %0d beats", beat, len + 1);
            timeouts++;
        end
        rready = 1'b1;
    endtask

    task automatic check_reset_outputs();
        @(negedge clk);
        compare_value("arready", 1, arready);
        compare_value("awready", 1, awready);
        compare_value("wready", 0, wready);
        compare_value("rvalid", 0, rvalid);
        compare_value("bvalid", 0, bvalid);
    endtask

    task automatic incr_write_read();
        fill_beats(8, 4'hf);
        write_burst(4'h5, 'h40, 7, 2, axi_mem_pkg::INCR);
        read_burst(4'h9, 'h40, 7, 2, axi_mem_pkg::INCR, 1'b0);
    endtask

    task automatic byte_writes();
        fill_beats(4, 4'h0);
        for (int i = 0; i < 4; i++)
            beat_strb[i] = 4'b0001 << i;             // Lane of byte 0x100 + i
        write_burst(4'h2, 'h100, 3, 0, axi_mem_pkg::INCR);
        beat_strb[0] = 4'b0100;                      // Lone byte at 0x4a
        write_burst(4'h3, 'h4a, 0, 0, axi_mem_pkg::INCR);
        read_burst(4'h4, 'h100, 0, 2, axi_mem_pkg::INCR, 1'b0);
        read_burst(4'h6, 'h48, 0, 2, axi_mem_pkg::INCR, 1'b0);
    endtask

    task automatic wrap_read();
        fill_beats(4, 4'hf);
        write_burst(4'h1, 'h80, 3, 2, axi_mem_pkg::INCR);
        read_burst(4'h7, 'h88, 3, 2, axi_mem_pkg::WRAP, 1'b0);  // 0x88 0x8c 0x80 0x84
    endtask

    task automatic fixed_write();
        fill_beats(3, 4'hf);
        write_burst(4'ha, 'hc0, 2, 2, axi_mem_pkg::FIXED);
        read_burst(4'hb, 'hc0, 0, 2, axi_mem_pkg::INCR, 1'b0);
    endtask

    task automatic out_of_range();
        fill_beats(4, 4'hf);
        write_burst(4'hc, 'h3f0, 3, 2, axi_mem_pkg::INCR);
        fill_beats(2, 4'hf);
        write_burst(4'hd, 'h3fe, 1, 2, axi_mem_pkg::INCR);     // Both beats cross the end
        read_burst(4'he, 'h3f8, 3, 2, axi_mem_pkg::INCR, 1'b0); // Last two beats past it
    endtask

    task automatic backpressure_read();
        fill_beats(16, 4'hf);
        write_burst(4'h8, 'h200, 15, 2, axi_mem_pkg::INCR);
        read_burst(4'hf, 'h200, 15, 2, axi_mem_pkg::INCR, 1'b1);
    endtask

    initial begin
        reset   = 1'b0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = axi_mem_pkg::INCR;
        rready  = 1'b0;
        awvalid = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = axi_mem_pkg::INCR;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        bready  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;
        check_reset_outputs();
        advance_cycle();
        incr_write_read();
        byte_writes();
        wrap_read();
        fixed_write();
        out_of_range();
        backpressure_read();
        $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* source/axi_mem_top.sv */
// AXI4 slave memory top level, 1 KiB on a 32-bit bus
// Burst engine, four byte-lane banks and the R stage behind plain AXI ports
`timescale 1ns/1ps

module axi_mem_top (
    input  logic                clk,
    input  logic                reset,
    // AR
    input  logic                arvalid,
    output logic                arready,
    input  axi_mem_pkg::id_t    arid,
    input  axi_mem_pkg::addr_t  araddr,
    input  axi_mem_pkg::len_t   arlen,
    input  axi_mem_pkg::size_t  arsize,
    input  axi_mem_pkg::burst_t arburst,
    // R
    output logic                rvalid,
    input  logic                rready,
    output axi_mem_pkg::id_t    rid,
    output axi_mem_pkg::data_t  rdata,
    output axi_mem_pkg::resp_t  rresp,
    output logic                rlast,
    // AW
    input  logic                awvalid,
    output logic                awready,
    input  axi_mem_pkg::id_t    awid,
    input  axi_mem_pkg::addr_t  awaddr,
    input  axi_mem_pkg::len_t   awlen,
    input  axi_mem_pkg::size_t  awsize,
    input  axi_mem_pkg::burst_t awburst,
    // W
    input  logic                wvalid,
    output logic                wready,
    input  axi_mem_pkg::data_t  wdata,
    input  axi_mem_pkg::strb_t  wstrb,
    input  logic                wlast,
    // B
    output logic                bvalid,
    input  logic                bready,
    output axi_mem_pkg::id_t    bid,
    output axi_mem_pkg::resp_t  bresp
);

    mem_lane_if lanes ();
    beat_tag_if tags ();

    wire axi_mem_pkg::data_t lane_data;   // Bank read bytes, lane 0 lowest

    burst_engine u_engine (
        .clk, .reset,
        .arvalid, .arready, .arid, .araddr, .arlen, .arsize, .arburst,
        .awvalid, .awready, .awid, .awaddr, .awlen, .awsize, .awburst,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .bvalid, .bready, .bid, .bresp,
        .lanes  (lanes.engine),
        .tags   (tags.engine)
    );

    // Byte A lives in lane A mod 4, word A div 4
    for (genvar i = 0; i < axi_mem_pkg::LANES; i++) begin : g_lane
        byte_lane_bank #(.lane_index(i)) u_bank (
            .clk  (clk),
            .lane (lanes.bank)
        );
        assign lane_data[i*8 +: 8] = lanes.rd_byte[i];
    end

    read_response u_rresp (
        .clk, .reset,
        .tags      (tags.response),
        .lane_data (lane_data),
        .rvalid, .rready, .rid, .rdata, .rresp, .rlast
    );

endmodule

/* source/read_response.sv */
// AXI4 read data stage
// One beat register behind the banks, drives R and holds it under back-pressure
`timescale 1ns/1ps

module read_response (
    input  logic               clk,
    input  logic               reset,
    beat_tag_if.response       tags,
    input  axi_mem_pkg::data_t lane_data,   // Registered bytes of all banks
    output logic               rvalid,
    input  logic               rready,
    output axi_mem_pkg::id_t   rid,
    output axi_mem_pkg::data_t rdata,
    output axi_mem_pkg::resp_t rresp,
    output logic               rlast
);

    axi_mem_pkg::id_t id_q;
    logic             last_q;
    logic             err_q;

    // Free when empty or the held beat leaves this cycle
    assign tags.slot_free = !rvalid || rready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            rvalid <= 1'b0;
        else if (tags.issue)
            rvalid <= 1'b1;        // Banks capture the same edge
        else if (rready)
            rvalid <= 1'b0;
    end

    // Beat tag payload
    always_ff @(posedge clk) begin
        if (tags.issue) begin
            id_q   <= tags.id;
            last_q <= tags.last;
            err_q  <= tags.err;
        end
    end

    assign rid   = id_q;
    assign rlast = last_q;
    assign rdata = err_q ? '0 : lane_data;     // Error beats carry zero
    assign rresp = err_q ? axi_mem_pkg::RESP_DECERR : axi_mem_pkg::RESP_OKAY;

    a_r_stable: assert property (@(posedge clk) disable iff (!reset)
        (rvalid && !rready) |=> (rvalid && $stable({rid, rdata, rresp, rlast})));

endmodule

/* source/byte_lane_bank.sv */
// One byte lane of the slave memory
// Strobed byte write, read byte registered only on read enable
`timescale 1ns/1ps

module byte_lane_bank #(
    parameter int lane_index = 0     // Lane number on the data bus
) (
    input  logic    clk,
    mem_lane_if.bank lane
);

    axi_mem_pkg::byte_t mem [axi_mem_pkg::LANE_DEPTH];  // Undefined until written
    axi_mem_pkg::byte_t rd_q;

    // Write own byte when its strobe is set
    always_ff @(posedge clk) begin
        if (lane.we && lane.wstrb[lane_index])
            mem[lane.word_idx] <= lane.wdata[lane_index*8 +: 8];
    end

    // Read byte holds while re is low, keeps R stable under back-pressure
    always_ff @(posedge clk) begin
        if (lane.re)
            rd_q <= mem[lane.word_idx];
    end

    assign lane.rd_byte[lane_index] = rd_q;

endmodule

/* source/burst_engine.sv */
// AXI4 burst engine
// Accepts AR and AW one at a time, steps FIXED, INCR and WRAP addresses,
// writes W beats into the banks, issues read beats and drives B
`timescale 1ns/1ps

module burst_engine (
    input  logic                clk,
    input  logic                reset,
    // Read address channel
    input  logic                arvalid,
    output logic                arready,
    input  axi_mem_pkg::id_t    arid,
    input  axi_mem_pkg::addr_t  araddr,
    input  axi_mem_pkg::len_t   arlen,
    input  axi_mem_pkg::size_t  arsize,
    input  axi_mem_pkg::burst_t arburst,
    // Write address channel
    input  logic                awvalid,
    output logic                awready,
    input  axi_mem_pkg::id_t    awid,
    input  axi_mem_pkg::addr_t  awaddr,
    input  axi_mem_pkg::len_t   awlen,
    input  axi_mem_pkg::size_t  awsize,
    input  axi_mem_pkg::burst_t awburst,
    // Write data channel
    input  logic                wvalid,
    output logic                wready,
    input  axi_mem_pkg::data_t  wdata,
    input  axi_mem_pkg::strb_t  wstrb,
    input  logic                wlast,
    // Write response channel
    output logic                bvalid,
    input  logic                bready,
    output axi_mem_pkg::id_t    bid,
    output axi_mem_pkg::resp_t  bresp,
    mem_lane_if.engine          lanes,
    beat_tag_if.engine          tags
);

    axi_mem_pkg::engine_state_t state;
    axi_mem_pkg::id_t           id_q;       // Burst fields latched on acceptance
    axi_mem_pkg::addr_t         addr_q;     // Address of the current beat
    axi_mem_pkg::len_t          len_q;
    axi_mem_pkg::size_t         size_q;
    axi_mem_pkg::burst_t        burst_q;
    axi_mem_pkg::len_t          count;      // Beats done so far
    logic                       werr;       // Some write beat was out of range

    axi_mem_pkg::addr_t         nbytes;     // Bytes per beat
    axi_mem_pkg::addr_t         next_addr;
    logic                       beat_err;
    logic                       beat_last;
    logic                       ar_hs, aw_hs, w_hs, issue;

    assign arready = (state == axi_mem_pkg::IDLE);
    assign awready = (state == axi_mem_pkg::IDLE) && !arvalid;  // Read wins a tie
    assign wready  = (state == axi_mem_pkg::WRITE);
    assign bvalid  = (state == axi_mem_pkg::WRESP);
    assign bid     = id_q;
    assign bresp   = werr ? axi_mem_pkg::RESP_DECERR : axi_mem_pkg::RESP_OKAY;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign issue = (state == axi_mem_pkg::READ) && tags.slot_free;

    assign nbytes    = axi_mem_pkg::addr_t'(1) << size_q;
    assign beat_last = (count == len_q);
    // Beat must end inside the memory
    assign beat_err  = (33'(addr_q) + 33'(nbytes)) > 33'(axi_mem_pkg::MEM_BYTES);

    // Next beat address
    always_comb begin
        axi_mem_pkg::addr_t aligned;
        axi_mem_pkg::addr_t cont;
        axi_mem_pkg::addr_t wrap_base;
        aligned   = addr_q & ~(nbytes - 1);
        cont      = nbytes * (axi_mem_pkg::addr_t'(len_q) + 1);  // WRAP container size
        wrap_base = addr_q & ~(cont - 1);
        case (burst_q)
            axi_mem_pkg::FIXED: next_addr = addr_q;
            axi_mem_pkg::WRAP: begin
                if (aligned + nbytes >= wrap_base + cont)
                    next_addr = wrap_base;   // Back to container start
                else
                    next_addr = aligned + nbytes;
            end
            default: next_addr = aligned + nbytes;
        endcase
    end

    // Reads and writes share one word index into the banks
    assign lanes.word_idx = axi_mem_pkg::word_idx_t'(addr_q >> 2);
    assign lanes.wdata    = wdata;
    assign lanes.wstrb    = wstrb;
    assign lanes.we       = w_hs && !beat_err;   // Out of range beats write nothing
    assign lanes.re       = issue;

    assign tags.issue = issue;
    assign tags.id    = id_q;
    assign tags.last  = beat_last;
    assign tags.err   = beat_err;

    // Burst fields load on AR or AW and the address steps once per beat
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            id_q    <= arid;
            addr_q  <= araddr;
            len_q   <= arlen;
            size_q  <= arsize;
            burst_q <= arburst;
        end else if (aw_hs) begin
            id_q    <= awid;
            addr_q  <= awaddr;
            len_q   <= awlen;
            size_q  <= awsize;
            burst_q <= awburst;
        end else if (issue || w_hs) begin
            addr_q  <= next_addr;
        end
    end

    // Control FSM
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= axi_mem_pkg::IDLE;
            count <= '0;
            werr  <= 1'b0;
        end else begin
            case (state)
                axi_mem_pkg::IDLE: begin
                    count <= '0;
                    if (ar_hs) begin
                        state <= axi_mem_pkg::READ;
                    end else if (aw_hs) begin
                        state <= axi_mem_pkg::WRITE;
                        werr  <= 1'b0;           // Fresh write error for this burst
                    end
                end
                axi_mem_pkg::READ: if (issue) begin
                    count <= count + 1'b1;
                    if (beat_last) state <= axi_mem_pkg::IDLE;  // Last beat may still wait on R
                end
                axi_mem_pkg::WRITE: if (w_hs) begin
                    count <= count + 1'b1;
                    werr  <= werr | beat_err;
                    if (beat_last) state <= axi_mem_pkg::WRESP;
                end
                default: if (bready) state <= axi_mem_pkg::IDLE;  // WRESP
            endcase
        end
    end

    // Only 1, 2 and 4 byte beats fit the bus
    a_size_fits: assert property (@(posedge clk) disable iff (!reset)
        (ar_hs || aw_hs) |=> (size_q <= 3'd2));

    a_wrap_len: assert property (@(posedge clk) disable iff (!reset)
        (state != axi_mem_pkg::IDLE && burst_q == axi_mem_pkg::WRAP)
            |-> (len_q inside {8'd1, 8'd3, 8'd7, 8'd15}));

    // Master's wlast agrees with the counted length
    a_wlast_match: assert property (@(posedge clk) disable iff (!reset)
        w_hs |-> (wlast == beat_last));

endmodule

/* source/beat_tag_if.sv */
// Read beat tag from the burst engine to the read response stage
// Carries ID, last and error of each issued beat, slot_free flows back
`timescale 1ns/1ps

interface beat_tag_if;

    logic                 issue;      // Beat sent to the banks this cycle
    axi_mem_pkg::id_t     id;         // Burst ID to echo on R
    logic                 last;       // Final beat of the burst
    logic                 err;        // Beat address out of range
    logic                 slot_free;  // R register can take a beat

    modport engine   (output issue, id, last, err, input slot_free);
    modport response (input issue, id, last, err, output slot_free);

endinterface

/* source/mem_lane_if.sv */
// Burst engine to byte-lane bank connection
// Shared word index and write data, one read byte back per lane
`timescale 1ns/1ps

interface mem_lane_if;

    axi_mem_pkg::word_idx_t word_idx;   // Word within every bank
    axi_mem_pkg::data_t     wdata;      // Full bus word, each bank takes its byte
    axi_mem_pkg::strb_t     wstrb;      // One strobe bit per lane
    logic                   we;         // Write this cycle
    logic                   re;         // Capture read byte this cycle

    // Registered read byte, one driver per bank
    wire axi_mem_pkg::byte_t rd_byte [axi_mem_pkg::LANES];

    modport engine (
        output word_idx, wdata, wstrb, we, re
    );

    modport bank (
        input  word_idx, wdata, wstrb, we, re,
        output rd_byte
    );

endinterface

/* source/axi_mem_pkg.sv */
// AXI4 slave memory shared definitions
// Bus widths, field types, burst and response codes, bank geometry
package axi_mem_pkg;

    // Bus and field widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int LANES      = DATA_WIDTH / 8;     // Byte lanes on the data bus
    localparam int ID_WIDTH   = 4;

    // Memory geometry
    localparam int MEM_BYTES  = 1024;
    localparam int LANE_DEPTH = MEM_BYTES / LANES;  // Words held by each bank

    typedef logic [ADDR_WIDTH-1:0]         addr_t;
    typedef logic [DATA_WIDTH-1:0]         data_t;
    typedef logic [LANES-1:0]              strb_t;
    typedef logic [7:0]                    byte_t;
    typedef logic [ID_WIDTH-1:0]           id_t;
    typedef logic [7:0]                    len_t;   // Beats minus one
    typedef logic [2:0]                    size_t;  // log2 of bytes per beat
    typedef logic [$clog2(LANE_DEPTH)-1:0] word_idx_t;
    typedef logic [1:0]                    resp_t;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // AXI burst type encoding
    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_t;

    // Burst engine states
    typedef enum logic [1:0] {
        IDLE,   // Waiting for AR or AW
        READ,   // Issuing read beats to the banks
        WRITE,  // Taking W beats
        WRESP   // Holding the B response
    } engine_state_t;

endpackage
